// ==== files.f ====
+incdir+bench
logic/capture_pkg.sv
logic/sample_ram.sv
logic/sample_writer.sv
logic/axi_bram_reader.sv
logic/capture_top.sv
bench/capture_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the capture buffer testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing \
  -f files.f \
  --top-module capture_tb \
  -o capture_sim

./obj_dir/capture_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failure"

// ==== bench/capture_checks.svh ====
task automatic compare_sample(input string name, input sample_t exp_val,
                              input sample_t act_val);
  checks++;
  if (act_val !== exp_val)
  begin
    errors++;
    $display("Fail at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
  end
endtask

task automatic compare_status(input string name, input capture_status_t exp_val,
                              input capture_status_t act_val);
  checks++;
  if (act_val !== exp_val)
  begin
    errors++;
    $display("Fail at %0t: %s expected wrapped %b ptr %h, got wrapped %b ptr %h",
             $time, name, exp_val.wrapped, exp_val.wr_ptr, act_val.wrapped, act_val.wr_ptr);
  end
endtask

task automatic compare_resp(input string name, input logic [1:0] exp_val,
                            input logic [1:0] act_val);
  checks++;
  if (act_val !== exp_val)
  begin
    errors++;
    $display("Fail at %0t: %s expected %b, got %b", $time, name, exp_val, act_val);
  end
endtask

task automatic compare_flag(input string name, input logic exp_val, input logic act_val);
  checks++;
  if (act_val !== exp_val)
  begin
    errors++;
    $display("Fail at %0t: %s expected %b, got %b", $time, name, exp_val, act_val);
  end
endtask

task automatic note_timeout(input string what);
  timeouts++;
  errors++;
  $display("Timeout at %0t: the DUT never raised %s", $time, what);
endtask

// Response must not move while the host stalls
task automatic confirm_held(input axi_r_t first);
  compare_sample("s_axi_r.data", first.data, s_axi_r.data);
  compare_resp("s_axi_r.resp", first.resp, s_axi_r.resp);
  compare_flag("s_axi_rvalid", 1'b1, s_axi_rvalid);
  compare_flag("s_axi_arready", 1'b0, s_axi_arready);  // No second read accepted
endtask

// Returns at the negedge where arready is seen, arvalid stays as driven
task automatic wait_arready(output logic ok);
  int waited;
  waited = 0;
  @(negedge aclk);
  while (s_axi_arready !== 1'b1 && waited < WAIT_LIMIT)
  begin
    @(negedge aclk);
    waited++;
  end
  ok = (s_axi_arready === 1'b1);
  if (!ok)
  begin
    note_timeout("s_axi_arready");
  end
endtask

task automatic wait_rvalid(output logic ok);
  int waited;
  waited = 0;
  while (s_axi_rvalid !== 1'b1 && waited < WAIT_LIMIT)
  begin
    @(negedge aclk);
    waited++;
  end
  ok = (s_axi_rvalid === 1'b1);
  if (!ok)
  begin
    note_timeout("s_axi_rvalid");
  end
endtask

// One AXI4-Lite read, with a random rready stall of 0 to 5 cycles.
// The same address stays requested while the response waits, so the
// second beat is only accepted after the first transfer completes.
task automatic axi_read(input logic [31:0] addr, output axi_r_t beat,
                        output axi_r_t again);
  int   stall;
  logic ok;
  stall = int'(rand_word() % 6);
  beat  = '0;
  again = '0;
  @(posedge aclk);
  s_axi_ar      <= '{addr: addr};
  s_axi_arvalid <= 1'b1;
  s_axi_rready  <= 1'b0;
  wait_arready(ok);
  if (!ok)
  begin
    @(posedge aclk);
    s_axi_arvalid <= 1'b0;
    return;
  end
  @(posedge aclk);                // Handshake edge, arvalid stays up
  @(negedge aclk);
  compare_flag("s_axi_arready pulse", 1'b0, s_axi_arready);
  wait_rvalid(ok);
  if (!ok)
  begin
    @(posedge aclk);
    s_axi_arvalid <= 1'b0;
    return;
  end
  beat = s_axi_r;
  repeat (stall)
  begin
    @(posedge aclk);
    @(negedge aclk);
    confirm_held(beat);
  end
  @(posedge aclk);
  s_axi_rready <= 1'b1;
  @(negedge aclk);
  confirm_held(beat);
  @(posedge aclk);                // Transfer completes here
  s_axi_rready <= 1'b0;
  @(negedge aclk);
  compare_flag("s_axi_rvalid after transfer", 1'b0, s_axi_rvalid);
  wait_arready(ok);               // Pending request taken now
  if (!ok)
  begin
    @(posedge aclk);
    s_axi_arvalid <= 1'b0;
    return;
  end
  @(posedge aclk);
  s_axi_arvalid <= 1'b0;
  @(negedge aclk);
  wait_rvalid(ok);
  if (!ok)
  begin
    return;
  end
  again = s_axi_r;
  @(posedge aclk);
  s_axi_rready <= 1'b1;
  @(posedge aclk);
  s_axi_rready <= 1'b0;
  @(negedge aclk);
  compare_flag("s_axi_rvalid after transfer", 1'b0, s_axi_rvalid);
endtask

// ==== bench/capture_tb.sv ====
`timescale 1ns/10ps

module capture_tb
  import capture_pkg::*;
();

  localparam int WAIT_LIMIT = 40;  // Cycles allowed for any one wait

  logic       aclk;
  logic       aresetn;
  logic       capture_en;
  sample_t    sample_in;
  logic       sample_valid;
  axi_ar_t    s_axi_ar;
  logic       s_axi_arvalid;
  logic       s_axi_arready;
  axi_r_t     s_axi_r;
  logic       s_axi_rvalid;
  logic       s_axi_rready;

  int         seed;
  int         errors;
  int         checks;
  int         timeouts;

  sample_t    model_mem [0:RAM_DEPTH-1];  // Expected RAM contents
  bram_addr_t model_ptr;                  // Next index the model writes
  logic       model_wrapped;

  capture_top DUT (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .capture_en    (capture_en),
    .sample_in     (sample_in),
    .sample_valid  (sample_valid),
    .s_axi_ar      (s_axi_ar),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_r       (s_axi_r),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready)
  );

  initial
  begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  `include "capture_checks.svh"

  // Ring model: newest sample wins, index wraps at 1024
  function automatic void write_model(input sample_t data);
    model_mem[model_ptr] = data;
    if (model_ptr == 10'd1023)
    begin
      model_wrapped = 1'b1;
    end
    model_ptr = model_ptr + 1'b1;
  endfunction

  // Feeds samples with random gaps until count of them are accepted
  task automatic run_burst(input int count);
    int          taken;
    logic [31:0] coin;
    sample_t     data;
    taken = 0;
    @(posedge aclk);
    capture_en <= 1'b1;
    while (taken < count)
    begin
      coin = rand_word();
      data = rand_word();
      sample_valid <= coin[0];
      sample_in    <= data;
      if (coin[0])
      begin
        write_model(data);
        taken++;
      end
      @(posedge aclk);
    end
    capture_en   <= 1'b0;
    sample_valid <= 1'b0;
    repeat (3) @(posedge aclk);  // Last write lands in the RAM
  endtask

  // Valid samples with capture off, none may be stored
  task automatic present_while_disabled(input int cycles);
    repeat (cycles)
    begin
      @(posedge aclk);
      capture_en   <= 1'b0;
      sample_valid <= 1'b1;
      sample_in    <= rand_word();
    end
    @(posedge aclk);
    sample_valid <= 1'b0;
  endtask

  // Byte address bit 12 picks the status word, bits 11:2 the RAM index
  task automatic check_beat(input logic [31:0] addr, input axi_r_t beat);
    capture_status_t exp_status;
    capture_status_t act_status;
    compare_resp("s_axi_r.resp", RESP_OKAY, beat.resp);
    if (addr[12])
    begin
      exp_status = '{wrapped: model_wrapped, wr_ptr: model_ptr};
      act_status = '{wrapped: beat.data[16], wr_ptr: beat.data[9:0]};
      compare_status("status word", exp_status, act_status);
      compare_sample("status word unused bits", '0, beat.data & 32'hFFFE_FC00);
    end
    else
    begin
      compare_sample("s_axi_r.data", model_mem[addr[11:2]], beat.data);
    end
  endtask

  task automatic read_and_check(input logic [31:0] addr);
    axi_r_t beat;
    axi_r_t again;
    axi_read(addr, beat, again);
    check_beat(addr, beat);
    check_beat(addr, again);
  endtask

  initial
  begin
    int burst_len;
    seed          = 20;
    errors        = 0;
    checks        = 0;
    timeouts      = 0;
    model_ptr     = '0;
    model_wrapped = 1'b0;
    aresetn       <= 1'b0;
    capture_en    <= 1'b0;
    sample_in     <= '0;
    sample_valid  <= 1'b0;
    s_axi_ar      <= '0;
    s_axi_arvalid <= 1'b0;
    s_axi_rready  <= 1'b0;

    repeat (9)
    begin
      @(posedge aclk);
      @(negedge aclk);
      compare_flag("s_axi_arready in reset", 1'b0, s_axi_arready);
      compare_flag("s_axi_rvalid in reset", 1'b0, s_axi_rvalid);
    end
    @(posedge aclk);
    aresetn <= 1'b1;  // Tenth edge still sees reset
    @(negedge aclk);
    compare_flag("s_axi_arready after reset", 1'b0, s_axi_arready);
    compare_flag("s_axi_rvalid after reset", 1'b0, s_axi_rvalid);
    read_and_check(32'h0000_1000);

    // Partial fill
    present_while_disabled(20);
    burst_len = 300 + int'(rand_word() % 200);
    run_burst(burst_len);
    present_while_disabled(15);
    read_and_check(32'h0000_1000);
    for (int i = 0; i < int'(model_ptr); i++)
    begin
      read_and_check(32'(i) << 2);
    end

    // Past the end of the ring
    run_burst(1100 + int'(rand_word() % 64));
    read_and_check(32'h0000_1000);
    for (int i = 0; i < RAM_DEPTH; i++)
    begin
      read_and_check(32'(i) << 2);
    end

    repeat (300)
    begin
      read_and_check(rand_word());  // Any byte address, either region
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/capture_top.sv ====
`timescale 1ns/10ps

// Sample capture buffer with an AXI4-Lite read port for the host.
// The writer fills the RAM as a ring, the reader serves host reads
// of the RAM and of the ring status.
module capture_top
  import capture_pkg::*;
(
  input  logic    aclk,
  input  logic    aresetn,

  // Sample stream
  input  logic    capture_en,
  input  sample_t sample_in,
  input  logic    sample_valid,

  // AXI4-Lite read channels
  input  axi_ar_t s_axi_ar,
  input  logic    s_axi_arvalid,
  output logic    s_axi_arready,
  output axi_r_t  s_axi_r,
  output logic    s_axi_rvalid,
  input  logic    s_axi_rready
);

  ram_wr_t         wr;       // Writer to RAM
  bram_addr_t      rd_addr;  // Reader to RAM
  sample_t         rd_data;  // RAM to reader
  capture_status_t status;   // Writer to reader

  sample_writer u_writer (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .capture_en   (capture_en),
    .sample_in    (sample_in),
    .sample_valid (sample_valid),
    .wr           (wr),
    .status       (status)
  );

  sample_ram u_ram (
    .aclk    (aclk),
    .wr      (wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  axi_bram_reader u_reader (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_ar      (s_axi_ar),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_r       (s_axi_r),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .status        (status)
  );

endmodule

// ==== logic/axi_bram_reader.sv ====
`timescale 1ns/10ps

// AXI4-Lite read-only slave in front of the sample RAM.
// One read at a time. Handshake edge A issues the RAM read, edge A+1
// loads the response register, which then holds until rready.
// Byte addresses with bit 12 set return the capture status word.
module axi_bram_reader
  import capture_pkg::*;
(
  input  logic            aclk,
  input  logic            aresetn,

  // AXI4-Lite read address channel
  input  axi_ar_t         s_axi_ar,
  input  logic            s_axi_arvalid,
  output logic            s_axi_arready,

  // AXI4-Lite read data channel
  output axi_r_t          s_axi_r,
  output logic            s_axi_rvalid,
  input  logic            s_axi_rready,

  // RAM read port
  output bram_addr_t      rd_addr,
  input  sample_t         rd_data,

  // Writer state
  input  capture_status_t status
);

  logic                  arready_q;
  logic                  busy_q;        // RAM read in flight
  logic                  rvalid_q;
  logic                  status_sel_q;  // Region of the read in flight
  axi_r_t                r_q;           // Response register
  logic                  ar_hs;
  logic                  r_hs;
  logic                  resp_pending;
  logic [AXI_DATA_W-1:0] status_word;

  assign ar_hs        = arready_q & s_axi_arvalid;
  assign r_hs         = rvalid_q & s_axi_rready;
  assign resp_pending = busy_q | rvalid_q;

  // Decode stage

  // Word index from the byte address, bits 11:2
  assign rd_addr = s_axi_ar.addr[ADDR_LSB +: BRAM_ADDR_W];

  always_ff @(posedge aclk)
  begin
    if (ar_hs)
    begin
      status_sel_q <= s_axi_ar.addr[STATUS_SEL_BIT];
    end
  end

  // Execute stage, handshake control

  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      arready_q <= 1'b0;
      busy_q    <= 1'b0;
    end
    else
    begin
      // Single-cycle pulse, never while a response is outstanding
      arready_q <= s_axi_arvalid & ~arready_q & ~resp_pending;
      busy_q    <= ar_hs;  // RAM samples rd_addr on the handshake edge
    end
  end

  // Result stage

  // Status word zero-extended to the bus width
  always_comb
  begin
    status_word                     = '0;
    status_word[BRAM_ADDR_W-1:0]    = status.wr_ptr;
    status_word[STATUS_WRAP_BIT]    = status.wrapped;
  end

  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      rvalid_q <= 1'b0;
    end
    else if (busy_q)
    begin
      rvalid_q <= 1'b1;
    end
    else if (r_hs)
    begin
      rvalid_q <= 1'b0;
    end
  end

  // Loaded once per read, so data stays put under back-pressure
  always_ff @(posedge aclk)
  begin
    if (busy_q)
    begin
      r_q.data <= status_sel_q ? status_word : rd_data;
      r_q.resp <= RESP_OKAY;  // No error responses
    end
  end

  assign s_axi_arready = arready_q;
  assign s_axi_rvalid  = rvalid_q;
  assign s_axi_r       = r_q;

endmodule

// ==== logic/sample_writer.sv ====
`timescale 1ns/10ps

// Stores the incoming sample stream into the RAM as a ring.
// The reported pointer follows the RAM contents, so it moves one edge
// after the sample is accepted.
module sample_writer
  import capture_pkg::*;
(
  input  logic            aclk,
  input  logic            aresetn,
  input  logic            capture_en,
  input  sample_t         sample_in,
  input  logic            sample_valid,
  output ram_wr_t         wr,
  output capture_status_t status
);

  logic       accept;       // Sample taken on this edge
  bram_addr_t next_idx_q;   // Index for the next accepted sample
  logic       wr_en_q;      // Write command pending for the RAM
  bram_addr_t wr_addr_q;
  sample_t    wr_data_q;
  bram_addr_t wr_ptr_q;     // Pointer as seen by the host
  logic       wrapped_q;

  assign accept = sample_valid & capture_en;

  // Write command and allocation pointer
  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      wr_en_q    <= 1'b0;
      next_idx_q <= '0;
    end
    else
    begin
      wr_en_q <= accept;
      if (accept)
      begin
        next_idx_q <= next_idx_q + 1'b1;  // Rolls over at 1023
      end
    end
  end

  // Address and data of the write command
  always_ff @(posedge aclk)
  begin
    if (accept)
    begin
      wr_addr_q <= next_idx_q;
      wr_data_q <= sample_in;
    end
  end

  // Status follows the write that the RAM performs on this edge
  always_ff @(posedge aclk)
  begin
    if (~aresetn)
    begin
      wr_ptr_q  <= '0;
      wrapped_q <= 1'b0;
    end
    else if (wr_en_q)
    begin
      wr_ptr_q <= wr_addr_q + 1'b1;
      if (wr_addr_q == bram_addr_t'(RAM_DEPTH - 1))
      begin
        wrapped_q <= 1'b1;  // Sticky until reset
      end
    end
  end

  assign wr = '{
    en:   wr_en_q,
    addr: wr_addr_q,
    data: wr_data_q
  };

  assign status = '{
    wrapped: wrapped_q,
    wr_ptr:  wr_ptr_q
  };

endmodule

// ==== logic/sample_ram.sv ====
`timescale 1ns/10ps

// Simple dual-port block RAM, one write port and one registered read port.
// Read-first: a read of the word being written returns the old contents.
module sample_ram
  import capture_pkg::*;
(
  input  logic       aclk,
  input  ram_wr_t    wr,
  input  bram_addr_t rd_addr,
  output sample_t    rd_data
);

  sample_t mem [0:RAM_DEPTH-1];  // Sample storage
  sample_t rd_data_q;            // Output register

  // Write port
  always_ff @(posedge aclk)
  begin
    if (wr.en)
    begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Read port, loads every cycle
  always_ff @(posedge aclk)
  begin
    rd_data_q <= mem[rd_addr];  // Sees the value before this edge's write
  end

  assign rd_data = rd_data_q;

endmodule

// ==== logic/capture_pkg.sv ====
package capture_pkg;

  // Bus and sample widths
  localparam int AXI_ADDR_W  = 32;
  localparam int AXI_DATA_W  = 32;
  localparam int SAMPLE_W    = 32;
  localparam int BRAM_ADDR_W = 10;
  localparam int RAM_DEPTH   = 1 << BRAM_ADDR_W;  // 1024 words

  // Address map
  localparam int ADDR_LSB        = 2;   // Byte offset bits within a word
  localparam int STATUS_SEL_BIT  = 12;  // Set selects the status word
  localparam int STATUS_WRAP_BIT = 16;  // Wrapped flag position in the status word

  // AXI response codes
  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef logic [SAMPLE_W-1:0]    sample_t;
  typedef logic [BRAM_ADDR_W-1:0] bram_addr_t;

  // Write command from the writer to the RAM
  typedef struct packed {
    logic       en;
    bram_addr_t addr;
    sample_t    data;
  } ram_wr_t;

  // Ring state reported to the host
  typedef struct packed {
    logic       wrapped;  // Ring has filled at least once
    bram_addr_t wr_ptr;   // Next index to be written
  } capture_status_t;

  // AXI4-Lite read address channel payload
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
  } axi_ar_t;

  // AXI4-Lite read data channel payload
  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
  } axi_r_t;

endpackage
